//--- rv_alu_core.f
+incdir+tests
logic/rv_alu_pkg.sv
logic/inst_receiver.sv
logic/inst_decoder.sv
logic/gpr_file.sv
logic/alu.sv
logic/result_sender.sv
logic/rv_alu_core.sv
tests/tb_rv_alu_core.sv

//--- Bender.yml
package:
  name: rv_alu_core

sources:
  - logic/rv_alu_pkg.sv
  - logic/inst_receiver.sv
  - logic/inst_decoder.sv
  - logic/gpr_file.sv
  - logic/alu.sv
  - logic/result_sender.sv
  - logic/rv_alu_core.sv
  - target: test
    include_dirs:
      - tests
    files:
      - tests/tb_rv_alu_core.sv

//--- tests/rv_ref_model.svh
`ifndef RV_REF_MODEL_SVH
`define RV_REF_MODEL_SVH

// Shadow copy of x0 to x31, kept in step with the instructions sent to the DUT.
logic [31:0] shadow [32];

// R-type word for the OP class.
function automatic logic [31:0] r_type(input logic [6:0] f7, input logic [4:0] rs2,
		input logic [4:0] rs1, input logic [2:0] f3, input logic [4:0] rd);
	return {f7, rs2, rs1, f3, rd, 7'b0110011};
endfunction

// I-type word for the OP-IMM class.
function automatic logic [31:0] i_type(input logic [11:0] imm12, input logic [4:0] rs1,
		input logic [2:0] f3, input logic [4:0] rd);
	return {imm12, rs1, f3, rd, 7'b0010011};
endfunction

// Predicts {illegal, rd, data} for one word and commits a legal write to the shadow.
function automatic logic [37:0] model_step(input logic [31:0] inst);
	logic [6:0]  opc;
	logic [2:0]  f3;
	logic [6:0]  f7;
	logic [4:0]  rd;
	logic [4:0]  sh;
	logic [31:0] a;
	logic [31:0] b;
	logic [31:0] r;
	logic        alt;
	logic        bad;
	opc = inst[6:0];
	f3  = inst[14:12];
	f7  = inst[31:25];
	rd  = inst[11:7];
	a   = shadow[inst[19:15]];
	alt = (f7 == 7'b0100000);
	bad = 1'b0;
	if (opc == 7'b0110011) begin
		b   = shadow[inst[24:20]];
		bad = !(f7 == 7'b0 || (alt && (f3 == 3'd0 || f3 == 3'd5))); // Only SUB and SRA use funct7.
	end else if (opc == 7'b0010011) begin
		b = {{20{inst[31]}}, inst[31:20]};
		if (f3 == 3'd1 || f3 == 3'd5) begin
			b   = {27'd0, inst[24:20]}; // Shift amount field.
			bad = !(f7 == 7'b0 || (alt && f3 == 3'd5));
		end else begin
			alt = 1'b0; // Upper immediate bits are plain data here.
		end
	end else begin
		b   = 32'd0;
		bad = 1'b1;
	end
	sh = b[4:0];
	case (f3)
		3'd0: r = alt ? a - b : a + b;
		3'd1: r = a << sh;
		3'd2: r = (a[31] != b[31]) ? {31'd0, a[31]} : {31'd0, a < b}; // Signed compare by sign bits.
		3'd3: r = {31'd0, a < b};
		3'd4: r = a ^ b;
		3'd5: r = (a >> sh) | ((alt && a[31]) ? ~(32'hffff_ffff >> sh) : 32'd0);
		3'd6: r = a | b;
		default: r = a & b;
	endcase
	if (bad)
		r = 32'd0; // An illegal word reports zero and writes nothing.
	else if (rd != 5'd0)
		shadow[rd] = r;
	return {bad, rd, r};
endfunction

`endif

//--- tests/tb_rv_alu_core.sv
`timescale 1ns/10ps
`default_nettype none

module tb_rv_alu_core;

	localparam int CLK_PERIOD      = 40;
	localparam int RESET_CYCLES    = 8;
	localparam int CYCLES_PER_INST = 20; // Watchdog budget per instruction.
	localparam int NUM_INSTS       = 6 + 93 + 200 + 150 + 6 + 10 + 6;

	logic        clk;
	logic        rst_n;
	logic        in_req;
	logic [31:0] in_inst;
	logic        in_ack;
	logic        res_ack;
	logic        res_req;
	logic [4:0]  res_rd;
	logic [31:0] res_data;
	logic        res_illegal;

	logic [37:0] exp_q [$]; // Predicted {illegal, rd, data}, oldest first.
	logic [37:0] got_q [$]; // Results as the DUT presented them.
	string       cur_test;
	int          test_checks;
	int          test_errors;
	int          total_checks;
	int          total_errors;
	int          num_tests;
	int          accepted;     // Instructions whose in_ack was seen.
	int          acked_done;   // Output handshakes completed.
	int          results_seen;
	int          ack_hold;     // Fixed res_ack delay in cycles, or -1 for a random one.

	`include "rv_ref_model.svh"

	rv_alu_core UUT (
		.clk(clk),
		.rst_n(rst_n),
		.in_req(in_req),
		.in_inst(in_inst),
		.res_ack(res_ack),
		.in_ack(in_ack),
		.res_req(res_req),
		.res_rd(res_rd),
		.res_data(res_data),
		.res_illegal(res_illegal)
	);

	always #(CLK_PERIOD / 2) clk = ~clk;

	// Records each result on the output side, then answers with res_ack.
	always begin : responder
		int delay;
		@(posedge clk);
		#2;
		if (rst_n && res_req && !res_ack) begin
			got_q.push_back({res_illegal, res_rd, res_data});
			results_seen++;
			delay = (ack_hold >= 0) ? ack_hold : $urandom_range(0, 5);
			if (delay > 0) begin
				repeat (delay) @(posedge clk);
				#2;
			end
			res_ack = 1'b1;
			while (res_req) begin
				@(posedge clk);
				#2;
			end
			res_ack = 1'b0;
			acked_done++; // The core may take the next word from here on.
		end
	end

	// Four-phase input handshake for one word.
	task automatic send_inst(input logic [31:0] inst);
		in_inst = inst;
		in_req  = 1'b1;
		@(posedge clk);
		#2;
		while (!in_ack) begin
			@(posedge clk);
			#2;
		end
		test_checks++;
		if (acked_done != accepted) begin
			$display("%s: in_ack rose while %0d earlier result(s) were still unacknowledged",
				cur_test, accepted - acked_done);
			test_errors++;
		end
		accepted++;
		in_req  = 1'b0;
		in_inst = $urandom; // The core must work from its own captured copy.
		while (in_ack) begin
			@(posedge clk);
			#2;
		end
	endtask

	task automatic run_inst(input logic [31:0] inst);
		exp_q.push_back(model_step(inst));
		send_inst(inst);
	endtask

	// Compares results in order until every prediction has been matched.
	task automatic drain_results();
		logic [37:0] exp_v;
		logic [37:0] got_v;
		while (exp_q.size() > 0) begin
			while (got_q.size() == 0) begin
				@(posedge clk);
				#2;
			end
			exp_v = exp_q.pop_front();
			got_v = got_q.pop_front();
			test_checks++;
			if (got_v !== exp_v) begin
				$display("[ERROR] %s: expected rd=x%0d data=%h illegal=%b,",
					cur_test, exp_v[36:32], exp_v[31:0], exp_v[37],
					" actual rd=x%0d data=%h illegal=%b", got_v[36:32], got_v[31:0], got_v[37]);
				test_errors++;
			end
		end
	endtask

	task automatic start_test(input string name);
		cur_test    = name;
		test_checks = 0;
		test_errors = 0;
	endtask

	task automatic end_test();
		drain_results();
		$display("Test %-12s %0d checks, %0d errors", cur_test, test_checks, test_errors);
		num_tests++;
		total_checks += test_checks;
		total_errors += test_errors;
	endtask

	task automatic check_reset_state();
		start_test("reset");
		for (int n = 0; n < 6; n++)
			run_inst(r_type(7'b0, $urandom_range(1, 31), $urandom_range(1, 31), 3'd0, 5'd5));
		end_test();
	endtask

	task automatic run_reg_reg();
		int f3;
		int alt;
		start_test("reg_reg");
		// Load every register with a wide value so that the operations see real data.
		for (int i = 1; i < 32; i++) begin
			run_inst(i_type($urandom_range(0, 4095), 5'd0, 3'd0, i));
			run_inst(i_type($urandom_range(0, 31), i, 3'd1, i));
			run_inst(i_type($urandom_range(0, 4095), i, 3'd4, i));
		end
		for (int n = 0; n < 200; n++) begin
			f3  = $urandom_range(0, 7);
			alt = (f3 == 0 || f3 == 5) ? $urandom_range(0, 1) : 0;
			run_inst(r_type(alt ? 7'b0100000 : 7'b0, $urandom_range(0, 31),
				$urandom_range(0, 31), f3, $urandom_range(1, 31)));
		end
		end_test();
	endtask

	task automatic run_reg_imm();
		int          f3;
		logic [4:0]  shamt;
		logic [11:0] imm12;
		start_test("reg_imm");
		for (int n = 0; n < 150; n++) begin
			f3    = $urandom_range(0, 7);
			shamt = $urandom_range(0, 31);
			if (f3 == 1)
				imm12 = {7'b0, shamt};
			else if (f3 == 5)
				imm12 = {($urandom_range(0, 1) == 1) ? 7'b0100000 : 7'b0, shamt}; // SRAI or SRLI.
			else
				imm12 = $urandom_range(0, 4095); // Half of these are negative.
			run_inst(i_type(imm12, $urandom_range(0, 31), f3, $urandom_range(1, 31)));
		end
		end_test();
	endtask

	task automatic keep_x0_zero();
		start_test("x0_zero");
		run_inst(i_type(12'h7ff, 5'd3, 3'd0, 5'd0));
		run_inst(r_type(7'b0, 5'd2, 5'd1, 3'd6, 5'd0));
		run_inst(r_type(7'b0100000, 5'd4, 5'd5, 3'd0, 5'd0));
		run_inst(r_type(7'b0, 5'd0, 5'd0, 3'd0, 5'd8)); // Reads x0 on both ports.
		run_inst(i_type(12'h000, 5'd0, 3'd6, 5'd9));
		run_inst(r_type(7'b0, 5'd7, 5'd0, 3'd3, 5'd10));
		end_test();
	endtask

	task automatic reject_illegal();
		logic [31:0] words [5];
		start_test("illegal");
		words[0] = {25'($urandom_range(0, 33554431)), 7'b0110111}; // LUI is not supported.
		words[1] = {25'($urandom_range(0, 33554431)), 7'b1111111};
		words[2] = r_type(7'b0000001, 5'd6, 5'd7, 3'd0, $urandom_range(1, 31));
		words[3] = r_type(7'b0100000, 5'd2, 5'd3, 3'd1, $urandom_range(1, 31));
		words[4] = i_type({7'b0100000, 5'd3}, 5'd4, 3'd1, $urandom_range(1, 31));
		for (int n = 0; n < 5; n++) begin
			run_inst(words[n]);
			run_inst(r_type(7'b0, 5'd0, words[n][11:7], 3'd0, words[n][11:7])); // Reads rd back.
		end
		end_test();
	endtask

	task automatic hold_off_results();
		start_test("backpressure");
		ack_hold = 40; // Each result waits this long for res_ack.
		for (int n = 0; n < 6; n++)
			run_inst(r_type(7'b0, $urandom_range(0, 31), $urandom_range(0, 31),
				$urandom_range(0, 7), $urandom_range(1, 31)));
		drain_results();
		ack_hold = -1;
		end_test();
	endtask

	initial begin : watchdog
		#(NUM_INSTS * CYCLES_PER_INST * CLK_PERIOD);
		$display("Simulation hung: tests did not finish within %0d ns",
			NUM_INSTS * CYCLES_PER_INST * CLK_PERIOD);
		$display("** FAIL **");
		$finish;
	end

	initial begin : main
		int seed;
		clk          = 1'b0;
		rst_n        = 1'b0;
		in_req       = 1'b0;
		in_inst      = 32'd0;
		res_ack      = 1'b0;
		ack_hold     = -1;
		test_checks  = 0;
		test_errors  = 0;
		total_checks = 0;
		total_errors = 0;
		num_tests    = 0;
		accepted     = 0;
		acked_done   = 0;
		results_seen = 0;
		seed         = 25;
		void'($urandom(seed));
		for (int i = 0; i < 32; i++)
			shadow[i] = 32'd0; // Matches the cleared register file.
		repeat (RESET_CYCLES) @(posedge clk);
		#2;
		rst_n = 1'b1;
		@(posedge clk);
		#2;
		check_reset_state();
		run_reg_reg();
		run_reg_imm();
		keep_x0_zero();
		reject_illegal();
		hold_off_results();
		repeat (20) @(posedge clk); // Room for a stray extra result to show up.
		#2;
		if (got_q.size() != 0 || results_seen != accepted) begin
			$display("Got %0d results for %0d accepted instructions", results_seen, accepted);
			total_errors++;
		end
		$display("Summary: %0d tests, %0d checks, %0d errors",
			num_tests, total_checks, total_errors);
		if (total_errors == 0) begin
			$display("** PASS **");
		end else begin
			$display("** FAIL **");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- logic/rv_alu_core.sv
`timescale 1ns/10ps
`default_nettype none

module rv_alu_core (
	input  wire                     clk,
	input  wire                     rst_n,
	input  wire                     in_req,
	input  wire rv_alu_pkg::inst_t  in_inst,
	input  wire                     res_ack,
	output logic                    in_ack,
	output logic                    res_req,
	output rv_alu_pkg::reg_addr_t   res_rd,
	output rv_alu_pkg::xlen_t       res_data,
	output logic                    res_illegal
);

	import rv_alu_pkg::*;

	logic      issue_valid;
	inst_t     issue_inst;
	logic      dec_valid;
	reg_addr_t rs1_addr;
	reg_addr_t rs2_addr;
	reg_addr_t rd_addr;
	logic      rs1_ren;
	logic      rs2_ren;
	logic      use_imm;
	xlen_t     imm;
	alu_op_t   alu_op;
	logic      illegal;
	xlen_t     rs1_data;
	xlen_t     rs2_data;
	logic      wb_en;
	reg_addr_t wb_addr;
	xlen_t     wb_data;
	logic      ex_valid;
	reg_addr_t ex_rd;
	xlen_t     ex_data;
	logic      ex_illegal;
	logic      busy; // Holds off the next instruction until the result is taken.

	inst_receiver u_rx (
		.clk, .rst_n, .in_req, .in_inst, .busy,
		.in_ack, .issue_valid, .issue_inst
	);

	inst_decoder u_dec (
		.clk, .rst_n, .issue_valid, .issue_inst,
		.dec_valid, .rs1_addr, .rs2_addr, .rd_addr, .rs1_ren, .rs2_ren,
		.use_imm, .imm, .alu_op, .illegal
	);

	gpr_file u_gpr (
		.clk, .rst_n, .rs1_ren, .rs2_ren, .rs1_addr, .rs2_addr,
		.wb_en, .wb_addr, .wb_data, .rs1_data, .rs2_data
	);

	alu u_alu (
		.clk, .rst_n, .dec_valid, .rd_addr, .rs1_data, .rs2_data, .imm, .use_imm,
		.alu_op, .illegal, .wb_en, .wb_addr, .wb_data,
		.ex_valid, .ex_rd, .ex_data, .ex_illegal
	);

	result_sender u_tx (
		.clk, .rst_n, .ex_valid, .ex_rd, .ex_data, .ex_illegal, .res_ack,
		.res_req, .res_rd, .res_data, .res_illegal, .busy
	);

endmodule

`default_nettype wire

//--- logic/result_sender.sv
`timescale 1ns/10ps
`default_nettype none

module result_sender (
	input  wire                         clk,
	input  wire                         rst_n,
	input  wire                         ex_valid,
	input  wire rv_alu_pkg::reg_addr_t  ex_rd,
	input  wire rv_alu_pkg::xlen_t      ex_data,
	input  wire                         ex_illegal,
	input  wire                         res_ack,
	output logic                        res_req,
	output rv_alu_pkg::reg_addr_t       res_rd,
	output rv_alu_pkg::xlen_t           res_data,
	output logic                        res_illegal,
	output logic                        busy
);

	typedef enum logic [1:0] {IDLE, REQ, WAIT_ACK_LOW} tx_state_t;

	tx_state_t state;
	logic      load;

	assign load = (state == IDLE) && ex_valid;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state   <= IDLE;
			res_req <= 1'b0;
		end else begin
			case (state)
				IDLE: begin
					if (ex_valid) begin
						res_req <= 1'b1; // Result is latched on the same edge.
						state   <= REQ;
					end
				end
				REQ: begin
					if (res_ack) begin
						res_req <= 1'b0;
						state   <= WAIT_ACK_LOW;
					end
				end
				WAIT_ACK_LOW: begin
					if (!res_ack)
						state <= IDLE; // Handshake is back to zero.
				end
				default: state <= IDLE;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (load) begin
			res_rd      <= ex_rd;
			res_data    <= ex_data;
			res_illegal <= ex_illegal;
		end
	end

	// Busy covers the cycle ex_valid arrives and the whole output handshake.
	assign busy = ex_valid || (state != IDLE);

	a_res_stable: assert property (@(posedge clk) disable iff (!rst_n)
		res_req && $past(res_req) |->
			$stable(res_rd) && $stable(res_data) && $stable(res_illegal))
		else $error("result changed while res_req was high");

endmodule

`default_nettype wire

//--- logic/alu.sv
`timescale 1ns/10ps
`default_nettype none

module alu (
	input  wire                         clk,
	input  wire                         rst_n,
	input  wire                         dec_valid,
	input  wire rv_alu_pkg::reg_addr_t  rd_addr,
	input  wire rv_alu_pkg::xlen_t      rs1_data,
	input  wire rv_alu_pkg::xlen_t      rs2_data,
	input  wire rv_alu_pkg::xlen_t      imm,
	input  wire                         use_imm,
	input  wire rv_alu_pkg::alu_op_t    alu_op,
	input  wire                         illegal,
	output logic                        wb_en,
	output rv_alu_pkg::reg_addr_t       wb_addr,
	output rv_alu_pkg::xlen_t           wb_data,
	output logic                        ex_valid,
	output rv_alu_pkg::reg_addr_t       ex_rd,
	output rv_alu_pkg::xlen_t           ex_data,
	output logic                        ex_illegal
);

	import rv_alu_pkg::*;

	xlen_t      op_b;   // Second operand after the immediate mux.
	xlen_t      result;
	logic [4:0] shamt;
	xlen_t      res_q;  // Result stage shared by writeback and sender.
	reg_addr_t  rd_q;

	assign op_b  = use_imm ? imm : rs2_data;
	assign shamt = op_b[4:0]; // RV32 shifts use the low five bits only.

	always_comb begin
		case (alu_op)
			ALU_ADD:  result = rs1_data + op_b;
			ALU_SUB:  result = rs1_data - op_b;
			ALU_SLL:  result = rs1_data << shamt;
			ALU_SLT:  result = xlen_t'($signed(rs1_data) < $signed(op_b));
			ALU_SLTU: result = xlen_t'(rs1_data < op_b);
			ALU_XOR:  result = rs1_data ^ op_b;
			ALU_SRL:  result = rs1_data >> shamt;
			ALU_SRA:  result = xlen_t'($signed(rs1_data) >>> shamt); // Sign bit fills in.
			ALU_OR:   result = rs1_data | op_b;
			ALU_AND:  result = rs1_data & op_b;
			default:  result = '0;
		endcase
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			wb_en      <= 1'b0;
			ex_valid   <= 1'b0;
			ex_illegal <= 1'b0;
		end else begin
			wb_en    <= dec_valid && !illegal; // No writeback for illegal words.
			ex_valid <= dec_valid;
			if (dec_valid)
				ex_illegal <= illegal;
		end
	end

	always_ff @(posedge clk) begin
		if (dec_valid) begin
			rd_q  <= rd_addr;
			res_q <= illegal ? '0 : result; // Illegal words report zero.
		end
	end

	assign wb_addr = rd_q;
	assign wb_data = res_q;
	assign ex_rd   = rd_q;
	assign ex_data = res_q;

endmodule

`default_nettype wire

//--- logic/gpr_file.sv
`timescale 1ns/10ps
`default_nettype none

module gpr_file (
	input  wire                         clk,
	input  wire                         rst_n,
	input  wire                         rs1_ren,
	input  wire                         rs2_ren,
	input  wire rv_alu_pkg::reg_addr_t  rs1_addr,
	input  wire rv_alu_pkg::reg_addr_t  rs2_addr,
	input  wire                         wb_en,
	input  wire rv_alu_pkg::reg_addr_t  wb_addr,
	input  wire rv_alu_pkg::xlen_t      wb_data,
	output rv_alu_pkg::xlen_t           rs1_data,
	output rv_alu_pkg::xlen_t           rs2_data
);

	import rv_alu_pkg::*;

	localparam int NUM_REGS = 2**REG_ADDR_W;

	xlen_t regs [NUM_REGS]; // Architectural registers x0 to x31.

	// One write port on the rising edge. Writes to x0 are dropped.
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < NUM_REGS; i++)
				regs[i] <= '0;
		end else if (wb_en && wb_addr != '0) begin
			regs[wb_addr] <= wb_data;
		end
	end

	// Read ports are combinational and read zero when disabled.
	assign rs1_data = rs1_ren ? regs[rs1_addr] : '0;
	assign rs2_data = rs2_ren ? regs[rs2_addr] : '0;

	// x0 must hold zero whatever the pipeline writes back.
	a_x0_zero: assert property (@(posedge clk) disable iff (!rst_n) regs[0] == '0)
		else $error("x0 holds a nonzero value");

endmodule

`default_nettype wire

//--- logic/inst_decoder.sv
`timescale 1ns/10ps
`default_nettype none

module inst_decoder (
	input  wire                     clk,
	input  wire                     rst_n,
	input  wire                     issue_valid,
	input  wire rv_alu_pkg::inst_t  issue_inst,
	output logic                    dec_valid,
	output rv_alu_pkg::reg_addr_t   rs1_addr,
	output rv_alu_pkg::reg_addr_t   rs2_addr,
	output rv_alu_pkg::reg_addr_t   rd_addr,
	output logic                    rs1_ren,
	output logic                    rs2_ren,
	output logic                    use_imm,
	output rv_alu_pkg::xlen_t       imm,
	output rv_alu_pkg::alu_op_t     alu_op,
	output logic                    illegal
);

	import rv_alu_pkg::*;

	logic [6:0] opcode;
	logic [6:0] funct7;
	logic [2:0] funct3;
	logic       d_illegal;
	logic       d_use_imm;
	logic       d_ren2;
	logic       d_alt; // Funct7 bit 5 picks SUB or SRA.
	xlen_t      d_imm;
	alu_op_t    d_op;

	assign opcode = issue_inst[6:0];
	assign funct3 = issue_inst[14:12];
	assign funct7 = issue_inst[31:25];

	always_comb begin
		d_illegal = 1'b0;
		d_use_imm = 1'b0;
		d_ren2    = 1'b0;
		d_alt     = 1'b0;
		d_imm     = {{(XLEN-12){issue_inst[31]}}, issue_inst[31:20]}; // I-type sign extension.
		case (opcode)
			OPC_OP: begin
				d_ren2 = 1'b1;
				if (funct7 == 7'b0100000 && (funct3 == 3'b000 || funct3 == 3'b101))
					d_alt = 1'b1;
				else if (funct7 != 7'b0000000)
					d_illegal = 1'b1; // No other funct7 is defined for OP.
			end
			OPC_OP_IMM: begin
				d_use_imm = 1'b1;
				if (funct3 == 3'b001 || funct3 == 3'b101) begin
					d_imm = {{(XLEN-5){1'b0}}, issue_inst[24:20]}; // Shamt only.
					if (funct3 == 3'b101 && funct7 == 7'b0100000)
						d_alt = 1'b1; // SRAI.
					else if (funct7 != 7'b0000000)
						d_illegal = 1'b1;
				end
			end
			default: d_illegal = 1'b1;
		endcase
		case (funct3)
			3'b000:  d_op = d_alt ? ALU_SUB : ALU_ADD;
			3'b001:  d_op = ALU_SLL;
			3'b010:  d_op = ALU_SLT;
			3'b011:  d_op = ALU_SLTU;
			3'b100:  d_op = ALU_XOR;
			3'b101:  d_op = d_alt ? ALU_SRA : ALU_SRL;
			3'b110:  d_op = ALU_OR;
			default: d_op = ALU_AND;
		endcase
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			dec_valid <= 1'b0;
			rs1_ren   <= 1'b0;
			rs2_ren   <= 1'b0;
			use_imm   <= 1'b0;
			illegal   <= 1'b0;
		end else begin
			dec_valid <= issue_valid;
			if (issue_valid) begin
				rs1_ren <= !d_illegal; // Illegal words touch no register.
				rs2_ren <= d_ren2 && !d_illegal;
				use_imm <= d_use_imm;
				illegal <= d_illegal;
			end
		end
	end

	// Register addresses, immediate and operation of the issued word.
	always_ff @(posedge clk) begin
		if (issue_valid) begin
			rd_addr  <= issue_inst[11:7];
			rs1_addr <= issue_inst[19:15];
			rs2_addr <= issue_inst[24:20];
			imm      <= d_imm;
			alu_op   <= d_op;
		end
	end

endmodule

`default_nettype wire

//--- logic/inst_receiver.sv
`timescale 1ns/10ps
`default_nettype none

module inst_receiver (
	input  wire                     clk,
	input  wire                     rst_n,
	input  wire                     in_req,
	input  wire rv_alu_pkg::inst_t  in_inst,
	input  wire                     busy,
	output logic                    in_ack,
	output logic                    issue_valid,
	output rv_alu_pkg::inst_t       issue_inst
);

	typedef enum logic [1:0] {IDLE, ACKED, WAIT_DONE} rx_state_t;

	rx_state_t state;
	logic      done_pend; // Set on accept, cleared once the result stage has shown busy.
	logic      accept;

	// Only one instruction may be in flight at a time.
	assign accept = (state == IDLE) && in_req && !busy;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state       <= IDLE;
			in_ack      <= 1'b0;
			issue_valid <= 1'b0;
			done_pend   <= 1'b0;
		end else begin
			issue_valid <= 1'b0; // Single cycle pulse towards decode.
			if (busy)
				done_pend <= 1'b0; // The sender has taken over this instruction.
			case (state)
				IDLE: begin
					if (accept) begin
						in_ack      <= 1'b1;
						issue_valid <= 1'b1;
						done_pend   <= 1'b1;
						state       <= ACKED;
					end
				end
				ACKED: begin
					// Return to zero half of the handshake.
					if (!in_req) begin
						in_ack <= 1'b0;
						state  <= WAIT_DONE;
					end
				end
				WAIT_DONE: begin
					// Busy must have risen and fallen again before the next word.
					if (!done_pend && !busy)
						state <= IDLE;
				end
				default: state <= IDLE;
			endcase
		end
	end

	// Holding register for the accepted word.
	always_ff @(posedge clk) begin
		if (accept)
			issue_inst <= in_inst;
	end

	// The environment must see in_req low before the core lets go of in_ack.
	a_ack_hold: assert property (@(posedge clk) disable iff (!rst_n)
		$fell(in_ack) |-> !$past(in_req))
		else $error("in_ack fell while in_req was still high");

endmodule

`default_nettype wire

//--- logic/rv_alu_pkg.sv
`default_nettype none

package rv_alu_pkg;

	localparam int XLEN       = 32; // Width of every register and result.
	localparam int REG_ADDR_W = 5;  // Enough to index x0 to x31.

	typedef logic [XLEN-1:0]       xlen_t;
	typedef logic [REG_ADDR_W-1:0] reg_addr_t;
	typedef logic [31:0]           inst_t; // Raw RV32I instruction word.
	typedef logic [3:0]            alu_op_t;

	// Internal ALU operation codes.
	// They are chosen freely and do not follow the funct3 encoding.
	localparam alu_op_t ALU_ADD  = 4'd0;
	localparam alu_op_t ALU_SUB  = 4'd1;
	localparam alu_op_t ALU_SLL  = 4'd2;
	localparam alu_op_t ALU_SLT  = 4'd3;
	localparam alu_op_t ALU_SLTU = 4'd4;
	localparam alu_op_t ALU_XOR  = 4'd5;
	localparam alu_op_t ALU_SRL  = 4'd6;
	localparam alu_op_t ALU_SRA  = 4'd7;
	localparam alu_op_t ALU_OR   = 4'd8;
	localparam alu_op_t ALU_AND  = 4'd9;

	// Major opcodes of the two supported instruction classes.
	localparam logic [6:0] OPC_OP     = 7'b0110011; // Register and register.
	localparam logic [6:0] OPC_OP_IMM = 7'b0010011; // Register and immediate.

endpackage

`default_nettype wire
